// File: logic/rv32_types.sv
// Shared RV32 slice types; only ADD/SUB/AND/OR/XOR/ADDI/LUI/LW are decoded, with two read ports
package rv32_types;

    typedef logic [31:0] rv32_word;
    typedef logic [31:0] rv_instr_t;

    localparam int CORE_RF_NUM_READ = 2;

    // ADDI x0, x0, 0
    localparam rv_instr_t RV_NOP = 32'h0000_0013;

    // funct fields of the supported subset
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_LW      = 3'b010;
    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_SUB     = 7'b0100000;

    typedef enum logic [6:0] {
        OP_REG  = 7'b0110011,
        OP_IMM  = 7'b0010011,
        OP_LUI  = 7'b0110111,
        OP_LOAD = 7'b0000011
    } rv_opcode_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_B
    } alu_op_t;

    typedef enum logic {
        WB_ALU,
        WB_LOAD
    } wb_src_t;

    typedef enum logic [1:0] {
        BYPASS_NONE,
        BYPASS_EXEC,
        BYPASS_WB
    } bypass_t;

    typedef struct packed {
        alu_op_t                            alu_op;
        logic                               use_imm;
        rv32_word                           imm;
        logic [4:0]                         rd;
        logic                               reg_write;
        wb_src_t                            wb_result_src;
        bypass_t [CORE_RF_NUM_READ - 1:0]   bypass_rs;
    } rv_control_t;

    typedef struct packed {
        rv32_word   pc;
        logic       generate_nop;
    } fetch_decode_buffer_t;

    typedef struct packed {
        rv32_word                           pc;
        rv_instr_t                          instr;
        rv_control_t                        control;
        rv32_word [CORE_RF_NUM_READ - 1:0]  reg_data;
    } decode_exec_buffer_t;

    typedef struct packed {
        logic       valid;
        logic [4:0] rd;
        wb_src_t    wb_result_src;
        rv32_word   result;
    } exec_wb_buffer_t;

    // Control word that writes nothing and needs no operand
    function automatic rv_control_t create_nop_ctrl();
        rv_control_t ctrl;
        ctrl.alu_op        = ALU_ADD;
        ctrl.use_imm       = 1'b0;
        ctrl.imm           = '0;
        ctrl.rd            = '0;
        ctrl.reg_write     = 1'b0;
        ctrl.wb_result_src = WB_ALU;
        for (int i = 0; i < CORE_RF_NUM_READ; i++) begin
            ctrl.bypass_rs[i] = BYPASS_NONE;
        end
        return ctrl;
    endfunction

endpackage

// File: logic/rv32_fetch_stage.sv
// Fetch for a one-cycle synchronous instruction memory; no branches, pc only steps by 4
`timescale 1ns/1ps

module rv32_fetch_stage (
    input  logic                             clk,
    input  logic                             resetn,
    input  logic                             stall,
    output rv32_types::rv32_word             imem_addr,
    output rv32_types::fetch_decode_buffer_t fetch_decode_buff
);
    import rv32_types::*;

    rv32_word pc;

    // Re-issue the address held in decode so the same word comes back
    assign imem_addr = stall ? fetch_decode_buff.pc : pc;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pc                             <= '0;
            fetch_decode_buff.pc           <= '0;
            fetch_decode_buff.generate_nop <= 1'b1;
        end else if (!stall) begin
            pc <= pc + 32'd4;
            // pc of the word that arrives from memory next cycle
            fetch_decode_buff.pc           <= pc;
            fetch_decode_buff.generate_nop <= 1'b0;
        end
    end

endmodule

// File: logic/rv32_decoder.sv
// Combinational decoder for the RV32 subset; any other encoding yields NOP control and no operand use
`timescale 1ns/1ps

module rv32_decoder (
    input  rv32_types::rv_instr_t                          instr,
    output rv32_types::rv_control_t                        control,
    output logic [rv32_types::CORE_RF_NUM_READ - 1:0]      use_rs
);
    import rv32_types::*;

    rv_opcode_t opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [4:0] rd;
    rv32_word   imm_i;
    rv32_word   imm_u;
    logic       supported;

    assign opcode = rv_opcode_t'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rd     = instr[11:7];
    assign imm_i  = {{20{instr[31]}}, instr[31:20]};
    assign imm_u  = {instr[31:12], 12'b0};

    always_comb begin
        control   = create_nop_ctrl();
        use_rs    = '0;
        supported = 1'b0;

        case (opcode)
            OP_REG: begin
                supported = 1'b1;
                use_rs    = '1;
                case ({funct7, funct3})
                    {F7_BASE, F3_ADD_SUB}: control.alu_op = ALU_ADD;
                    {F7_SUB, F3_ADD_SUB}:  control.alu_op = ALU_SUB;
                    {F7_BASE, F3_AND}:     control.alu_op = ALU_AND;
                    {F7_BASE, F3_OR}:      control.alu_op = ALU_OR;
                    {F7_BASE, F3_XOR}:     control.alu_op = ALU_XOR;
                    default:               supported = 1'b0;
                endcase
            end
            OP_IMM: begin
                // ADDI only
                supported       = (funct3 == F3_ADD_SUB);
                use_rs[0]       = 1'b1;
                control.use_imm = 1'b1;
                control.imm     = imm_i;
            end
            OP_LUI: begin
                supported       = 1'b1;
                control.alu_op  = ALU_PASS_B;
                control.use_imm = 1'b1;
                control.imm     = imm_u;
            end
            OP_LOAD: begin
                supported             = (funct3 == F3_LW);
                use_rs[0]             = 1'b1;
                control.use_imm       = 1'b1;
                control.imm           = imm_i;
                control.wb_result_src = WB_LOAD;
            end
            default: supported = 1'b0;
        endcase

        if (supported) begin
            control.rd        = rd;
            control.reg_write = (rd != 5'd0);
        end else begin
            control = create_nop_ctrl();
            use_rs  = '0;
        end
    end

endmodule

// File: logic/rv32_hazard_unit.sv
// Bypass and load-use detection against the execute and writeback buffers; rd of x0 never matches
`timescale 1ns/1ps

module rv32_hazard_unit (
    input  logic [rv32_types::CORE_RF_NUM_READ - 1:0]         use_rs,
    input  rv32_types::rv_instr_t                             current_instr,
    input  rv32_types::decode_exec_buffer_t                   decode_exec_buff,
    input  rv32_types::exec_wb_buffer_t                       exec_wb_buff,
    output logic                                              stall,
    output rv32_types::bypass_t [rv32_types::CORE_RF_NUM_READ - 1:0] bypass_rs
);
    import rv32_types::*;

    logic [4:0] rs_addr [CORE_RF_NUM_READ];

    assign rs_addr[0] = current_instr[19:15];
    assign rs_addr[1] = current_instr[24:20];

    always_comb begin
        stall = 1'b0;
        for (int i = 0; i < CORE_RF_NUM_READ; i++) begin
            bypass_rs[i] = BYPASS_NONE;
            if (use_rs[i]) begin
                // Newest producer first
                if (decode_exec_buff.control.reg_write &&
                    decode_exec_buff.control.rd == rs_addr[i]) begin
                    if (decode_exec_buff.control.wb_result_src == WB_LOAD) begin
                        // Load data not there yet, wait one cycle
                        stall = 1'b1;
                    end else begin
                        bypass_rs[i] = BYPASS_EXEC;
                    end
                end else if (exec_wb_buff.valid && exec_wb_buff.rd == rs_addr[i]) begin
                    bypass_rs[i] = BYPASS_WB;
                end
            end
        end
    end

endmodule

// File: logic/rv32_decode_stage.sv
// Decode stage; stall is combinational and a stalled cycle sends a NOP to execute
`timescale 1ns/1ps

module rv32_decode_stage (
    input  logic                                               clk,
    input  logic                                               resetn,
    input  rv32_types::fetch_decode_buffer_t                   fetch_decode_buff,
    input  rv32_types::rv_instr_t                              instr,
    input  rv32_types::rv32_word [rv32_types::CORE_RF_NUM_READ - 1:0] reg_data,
    input  rv32_types::exec_wb_buffer_t                        exec_wb_buff,
    output rv32_types::decode_exec_buffer_t                    decode_exec_buff,
    output logic                                               stall
);
    import rv32_types::*;

    rv_instr_t                          dec_instr;
    rv_control_t                        dec_control;
    logic [CORE_RF_NUM_READ - 1:0]      use_rs;
    bypass_t [CORE_RF_NUM_READ - 1:0]   bypass_rs;
    decode_exec_buffer_t                next_buff;

    // Fetch bubble after reset
    assign dec_instr = fetch_decode_buff.generate_nop ? RV_NOP : instr;

    rv32_decoder i_decoder (
        .instr   (dec_instr),
        .control (dec_control),
        .use_rs  (use_rs)
    );

    rv32_hazard_unit i_hazard (
        .use_rs           (use_rs),
        .current_instr    (dec_instr),
        .decode_exec_buff (decode_exec_buff),
        .exec_wb_buff     (exec_wb_buff),
        .stall            (stall),
        .bypass_rs        (bypass_rs)
    );

    always_comb begin
        next_buff.pc                = fetch_decode_buff.pc;
        next_buff.instr             = dec_instr;
        next_buff.reg_data          = reg_data;
        next_buff.control           = dec_control;
        next_buff.control.bypass_rs = bypass_rs;

        // Bubble into execute while the load finishes
        if (stall) begin
            next_buff.instr   = RV_NOP;
            next_buff.control = create_nop_ctrl();
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            decode_exec_buff.pc      <= '0;
            decode_exec_buff.instr   <= RV_NOP;
            decode_exec_buff.control <= create_nop_ctrl();
        end else begin
            decode_exec_buff <= next_buff;
        end
    end

endmodule

// File: logic/rv32_exec_stage.sv
// Execute stage; dmem_addr is valid for loads only and dmem_rdata must follow one cycle later
`timescale 1ns/1ps

module rv32_exec_stage (
    input  logic                            clk,
    input  logic                            resetn,
    input  rv32_types::decode_exec_buffer_t decode_exec_buff,
    input  rv32_types::rv32_word            dmem_rdata,
    output rv32_types::rv32_word            dmem_addr,
    output rv32_types::exec_wb_buffer_t     exec_wb_buff,
    output rv32_types::rv32_word            wb_data
);
    import rv32_types::*;

    rv_control_t ctrl;
    rv32_word    operand [CORE_RF_NUM_READ];
    rv32_word    alu_b;
    rv32_word    alu_result;
    rv32_word    wb_data_prev;

    assign ctrl = decode_exec_buff.control;

    // Writeback result is the load data when the buffered op is a load
    assign wb_data = (exec_wb_buff.wb_result_src == WB_LOAD) ? dmem_rdata : exec_wb_buff.result;

    // The register file missed the value that retired while this op sat in decode
    always_ff @(posedge clk) begin
        wb_data_prev <= wb_data;
    end

    always_comb begin
        for (int i = 0; i < CORE_RF_NUM_READ; i++) begin
            case (ctrl.bypass_rs[i])
                BYPASS_EXEC: operand[i] = exec_wb_buff.result;
                BYPASS_WB:   operand[i] = wb_data_prev;
                default:     operand[i] = decode_exec_buff.reg_data[i];
            endcase
        end
    end

    assign alu_b     = ctrl.use_imm ? ctrl.imm : operand[1];
    assign dmem_addr = operand[0] + ctrl.imm;

    always_comb begin
        case (ctrl.alu_op)
            ALU_ADD:    alu_result = operand[0] + alu_b;
            ALU_SUB:    alu_result = operand[0] - alu_b;
            ALU_AND:    alu_result = operand[0] & alu_b;
            ALU_OR:     alu_result = operand[0] | alu_b;
            ALU_XOR:    alu_result = operand[0] ^ alu_b;
            ALU_PASS_B: alu_result = alu_b;
            default:    alu_result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            exec_wb_buff.valid         <= 1'b0;
            exec_wb_buff.rd            <= '0;
            exec_wb_buff.wb_result_src <= WB_ALU;
        end else begin
            exec_wb_buff.valid         <= ctrl.reg_write;
            exec_wb_buff.rd            <= ctrl.rd;
            exec_wb_buff.wb_result_src <= ctrl.wb_result_src;
        end
        // Load address for loads, nobody reads it then
        exec_wb_buff.result <= alu_result;
    end

endmodule

// File: logic/rv32_regfile.sv
// 32x32 register file; reads are asynchronous, write lands at the clock edge, no reset
`timescale 1ns/1ps

module rv32_regfile (
    input  logic                                                clk,
    input  logic [4:0]                                          rs1_addr,
    input  logic [4:0]                                          rs2_addr,
    input  logic [4:0]                                          rd_addr,
    input  rv32_types::rv32_word                                rd_data,
    input  logic                                                write_en,
    output rv32_types::rv32_word [rv32_types::CORE_RF_NUM_READ - 1:0] rs_data
);
    import rv32_types::*;

    rv32_word regs [32];

    // x0 is never stored
    always_ff @(posedge clk) begin
        if (write_en && rd_addr != 5'd0) begin
            regs[rd_addr] <= rd_data;
        end
    end

    assign rs_data[0] = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
    assign rs_data[1] = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

endmodule

// File: logic/rv32_core_top.sv
// Four-stage RV32 subset core; both memories are external with one-cycle synchronous read
`timescale 1ns/1ps

module rv32_core_top (
    input  logic                 clk,
    input  logic                 resetn,
    output rv32_types::rv32_word imem_addr,
    input  rv32_types::rv_instr_t imem_rdata,
    output rv32_types::rv32_word dmem_addr,
    input  rv32_types::rv32_word dmem_rdata,
    output logic                 wb_valid,
    output logic [4:0]           wb_rd,
    output rv32_types::rv32_word wb_data,
    output logic                 stall
);
    import rv32_types::*;

    fetch_decode_buffer_t              fetch_decode_buff;
    decode_exec_buffer_t               decode_exec_buff;
    exec_wb_buffer_t                   exec_wb_buff;
    rv32_word [CORE_RF_NUM_READ - 1:0] reg_data;

    // Retirement trace is the register write port
    assign wb_valid = exec_wb_buff.valid;
    assign wb_rd    = exec_wb_buff.rd;

    rv32_fetch_stage i_fetch (
        .clk               (clk),
        .resetn            (resetn),
        .stall             (stall),
        .imem_addr         (imem_addr),
        .fetch_decode_buff (fetch_decode_buff)
    );

    rv32_regfile i_regfile (
        .clk      (clk),
        .rs1_addr (imem_rdata[19:15]),
        .rs2_addr (imem_rdata[24:20]),
        .rd_addr  (exec_wb_buff.rd),
        .rd_data  (wb_data),
        .write_en (exec_wb_buff.valid),
        .rs_data  (reg_data)
    );

    rv32_decode_stage i_decode (
        .clk               (clk),
        .resetn            (resetn),
        .fetch_decode_buff (fetch_decode_buff),
        .instr             (imem_rdata),
        .reg_data          (reg_data),
        .exec_wb_buff      (exec_wb_buff),
        .decode_exec_buff  (decode_exec_buff),
        .stall             (stall)
    );

    rv32_exec_stage i_exec (
        .clk              (clk),
        .resetn           (resetn),
        .decode_exec_buff (decode_exec_buff),
        .dmem_rdata       (dmem_rdata),
        .dmem_addr        (dmem_addr),
        .exec_wb_buff     (exec_wb_buff),
        .wb_data          (wb_data)
    );

endmodule

// File: sim/tb_clock_gen.sv
// Testbench clock and synchronous reset; reset is released 1 ns after a rising edge
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic resetn
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        resetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        resetn = 1'b1;
    end

endmodule

// File: sim/tb_core.sv
// Core testbench; memories answer 1 ns after the edge that follows the address and data is addr^5a5a0000
`timescale 1ns/1ps

module tb_core;
    import rv32_types::*;

    localparam rv32_word DMEM_XOR = 32'h5a5a_0000;

    logic       clk;
    logic       resetn;
    rv32_word   imem_addr;
    rv_instr_t  imem_rdata;
    rv32_word   dmem_addr;
    rv32_word   dmem_rdata;
    logic       wb_valid;
    logic [4:0] wb_rd;
    rv32_word   wb_data;
    logic       stall;

    rv_instr_t   prog [$];
    bit          stall_exp [$];
    logic [4:0]  exp_rd [$];
    rv32_word    exp_val [$];
    rv32_word    model_regs [32];
    logic [4:0]  prev_load_rd;
    int          stall_total;
    logic [31:0] lfsr_state;

    rv32_word imem_addr_q;
    rv32_word dmem_addr_q;
    rv32_word imem_addr_prev;
    logic     stall_prev;
    int       retire_count;
    int       stall_count;
    int       cycle_count;
    int       cycle_limit;

    tb_clock_gen #(.PERIOD_NS(100), .RESET_CYCLES(2)) i_clock_gen (
        .clk    (clk),
        .resetn (resetn)
    );

    rv32_core_top i_dut (
        .clk        (clk),
        .resetn     (resetn),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .dmem_addr  (dmem_addr),
        .dmem_rdata (dmem_rdata),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data),
        .stall      (stall)
    );

    task automatic report_failure();
        $display("Test failures found");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    function automatic rv32_word random_word();
        rv32_word w;
        w = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            w = {w[30:0], lfsr_state[0]};
        end
        return w;
    endfunction

    function automatic rv_instr_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic rv_instr_t enc_i(input logic [6:0] op, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic rv_instr_t enc_u(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, OP_LUI};
    endfunction

    // Appends one instruction and runs it on the reference model
    task automatic add_instr(input rv_instr_t w);
        logic [6:0] op;
        logic [2:0] f3;
        logic [6:0] f7;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        rv32_word   a;
        rv32_word   b;
        rv32_word   imm_i;
        rv32_word   res;
        logic       writes;
        logic       is_load;
        logic [1:0] uses;
        op      = w[6:0];
        f3      = w[14:12];
        f7      = w[31:25];
        rd      = w[11:7];
        rs1     = w[19:15];
        rs2     = w[24:20];
        a       = (rs1 == 5'd0) ? '0 : model_regs[rs1];
        b       = (rs2 == 5'd0) ? '0 : model_regs[rs2];
        imm_i   = {{20{w[31]}}, w[31:20]};
        res     = '0;
        writes  = 1'b0;
        is_load = 1'b0;
        uses    = 2'b00;
        if (op == 7'b0110011) begin
            uses   = 2'b11;
            writes = 1'b1;
            if (f7 == 7'h00 && f3 == 3'd0)      res = a + b;
            else if (f7 == 7'h20 && f3 == 3'd0) res = a - b;
            else if (f7 == 7'h00 && f3 == 3'd7) res = a & b;
            else if (f7 == 7'h00 && f3 == 3'd6) res = a | b;
            else if (f7 == 7'h00 && f3 == 3'd4) res = a ^ b;
            else begin
                uses   = 2'b00;
                writes = 1'b0;
            end
        end else if (op == 7'b0010011 && f3 == 3'd0) begin
            uses   = 2'b01;
            writes = 1'b1;
            res    = a + imm_i;
        end else if (op == 7'b0110111) begin
            writes = 1'b1;
            res    = {w[31:12], 12'h000};
        end else if (op == 7'b0000011 && f3 == 3'd2) begin
            uses    = 2'b01;
            writes  = 1'b1;
            is_load = 1'b1;
            res     = (a + imm_i) ^ DMEM_XOR;
        end
        // Load-use with the instruction just before
        if (prev_load_rd != 5'd0 &&
            ((uses[0] && rs1 == prev_load_rd) || (uses[1] && rs2 == prev_load_rd))) begin
            stall_exp.push_back(1'b1);
            stall_total++;
        end else begin
            stall_exp.push_back(1'b0);
        end
        prev_load_rd = (is_load && rd != 5'd0) ? rd : 5'd0;
        if (writes && rd != 5'd0) begin
            model_regs[rd] = res;
            exp_rd.push_back(rd);
            exp_val.push_back(res);
        end
        prog.push_back(w);
    endtask

    task automatic load_reg(input logic [4:0] rd, input rv32_word v);
        add_instr(enc_u(rd, v[31:12] + {19'd0, v[11]}));
        add_instr(enc_i(OP_IMM, F3_ADD_SUB, rd, rd, v[11:0]));
    endtask

    task automatic build_program();
        for (int r = 1; r <= 6; r++) begin
            load_reg(r[4:0], random_word());
        end
        // Dependent ALU chain through exec and writeback bypass
        add_instr(enc_r(F7_BASE, F3_ADD_SUB, 5'd7, 5'd1, 5'd2));
        add_instr(enc_r(F7_SUB, F3_ADD_SUB, 5'd8, 5'd7, 5'd3));
        add_instr(enc_r(F7_BASE, F3_AND, 5'd9, 5'd8, 5'd7));
        add_instr(enc_r(F7_BASE, F3_OR, 5'd10, 5'd9, 5'd4));
        add_instr(enc_r(F7_BASE, F3_XOR, 5'd11, 5'd10, 5'd9));
        add_instr(enc_i(OP_IMM, F3_ADD_SUB, 5'd12, 5'd11, 12'hffb));
        add_instr(enc_u(5'd13, 20'habcde));
        add_instr(enc_r(F7_BASE, F3_ADD_SUB, 5'd14, 5'd13, 5'd12));
        // Loads used at once and two instructions later
        add_instr(enc_i(OP_LOAD, F3_LW, 5'd15, 5'd1, 12'h010));
        add_instr(enc_r(F7_BASE, F3_ADD_SUB, 5'd16, 5'd15, 5'd2));
        add_instr(enc_i(OP_LOAD, F3_LW, 5'd17, 5'd3, 12'hff8));
        add_instr(enc_i(OP_IMM, F3_ADD_SUB, 5'd18, 5'd5, 12'h001));
        add_instr(enc_r(F7_BASE, F3_XOR, 5'd19, 5'd18, 5'd17));
        add_instr(enc_i(OP_LOAD, F3_LW, 5'd20, 5'd16, 12'h004));
        add_instr(enc_i(OP_LOAD, F3_LW, 5'd21, 5'd20, 12'h000));
        add_instr(enc_r(F7_SUB, F3_ADD_SUB, 5'd22, 5'd6, 5'd21));
        // x0 targets and unsupported encodings
        add_instr(enc_r(F7_BASE, F3_ADD_SUB, 5'd0, 5'd1, 5'd2));
        add_instr(enc_i(OP_IMM, F3_ADD_SUB, 5'd23, 5'd0, 12'h007));
        add_instr(32'h0000_0063);
        add_instr(enc_r(F7_BASE, 3'b001, 5'd24, 5'd1, 5'd2));
        add_instr(32'hffff_ffff);
        add_instr(enc_i(OP_LOAD, F3_LW, 5'd0, 5'd1, 12'h000));
        add_instr(enc_r(F7_BASE, F3_OR, 5'd25, 5'd0, 5'd23));
        add_instr(enc_i(OP_IMM, 3'b001, 5'd26, 5'd1, 12'h003));
        add_instr(enc_r(F7_BASE, F3_ADD_SUB, 5'd27, 5'd0, 5'd0));
    endtask

    function automatic rv_instr_t instr_at(input rv32_word addr);
        if ((addr >> 2) < prog.size()) return prog[addr >> 2];
        return RV_NOP;
    endfunction

    function automatic bit stall_expected_at(input rv32_word addr);
        if ((addr >> 2) < stall_exp.size()) return stall_exp[addr >> 2];
        return 1'b0;
    endfunction

    // Memories sample the address mid-cycle and answer after the next edge
    always @(negedge clk) begin
        imem_addr_q = imem_addr;
        dmem_addr_q = dmem_addr;
    end

    always begin
        @(posedge clk);
        #1;
        imem_rdata = instr_at(imem_addr_q);
        dmem_rdata = dmem_addr_q ^ DMEM_XOR;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles with %0d of %0d retirements seen",
                     cycle_count, retire_count, exp_rd.size());
            report_failure();
        end
    end

    always @(negedge clk) begin
        if (!resetn) begin
            if (cycle_count > 0) begin
                assert (wb_valid === 1'b0 && stall === 1'b0) else begin
                    $display("wb_valid or stall is not low during reset at %0t", $time);
                    report_failure();
                end
            end
            stall_prev = 1'b0;
        end else begin
            assert (!$isunknown({wb_valid, stall})) else begin
                $display("wb_valid or stall is unknown at %0t", $time);
                report_failure();
            end
            if (stall) begin
                stall_count++;
                assert (!stall_prev) else begin
                    $display("stall stayed high for a second cycle at %0t", $time);
                    report_failure();
                end
                assert (imem_addr === imem_addr_prev) else begin
                    $display("Fail time=%0t imem_addr expected %h actual %h",
                             $time, imem_addr_prev, imem_addr);
                    report_failure();
                end
                assert (stall_expected_at(imem_addr)) else begin
                    $display("stall raised at %0t for pc %h with no load-use hazard",
                             $time, imem_addr);
                    report_failure();
                end
            end
            if (wb_valid) begin
                assert (retire_count < exp_rd.size()) else begin
                    $display("Retirement of x%0d at %0t beyond the end of the program",
                             wb_rd, $time);
                    report_failure();
                end
                assert (wb_rd === exp_rd[retire_count]) else begin
                    $display("Fail time=%0t wb_rd expected %0d actual %0d",
                             $time, exp_rd[retire_count], wb_rd);
                    report_failure();
                end
                assert (wb_data === exp_val[retire_count]) else begin
                    $display("Fail time=%0t wb_data expected %h actual %h",
                             $time, exp_val[retire_count], wb_data);
                    report_failure();
                end
                retire_count++;
            end
            stall_prev = stall;
        end
        imem_addr_prev = imem_addr;
    end

    initial begin
        imem_rdata     = RV_NOP;
        dmem_rdata     = '0;
        imem_addr_q    = '0;
        dmem_addr_q    = '0;
        imem_addr_prev = '0;
        stall_prev     = 1'b0;
        retire_count   = 0;
        stall_count    = 0;
        cycle_count    = 0;
        stall_total    = 0;
        prev_load_rd   = 5'd0;
        lfsr_state     = 32'h7db9;
        build_program();
        cycle_limit = 3 * prog.size() + 20;

        wait (resetn);
        // Let the program tail and trailing NOPs drain
        while (imem_addr < prog.size() * 4 + 16) @(negedge clk);
        #1;
        if (retire_count == exp_rd.size() && stall_count == stall_total) begin
            $display("All tests passed!");
            $finish;
        end else begin
            $display("Retired %0d of %0d, stalls %0d against %0d expected",
                     retire_count, exp_rd.size(), stall_count, stall_total);
            report_failure();
        end
    end

endmodule

// File: sim.f
logic/rv32_types.sv
logic/rv32_fetch_stage.sv
logic/rv32_decoder.sv
logic/rv32_hazard_unit.sv
logic/rv32_decode_stage.sv
logic/rv32_exec_stage.sv
logic/rv32_regfile.sv
logic/rv32_core_top.sv
sim/tb_clock_gen.sv
sim/tb_core.sv
